//--- source/merge_pkg.sv
package merge_pkg;

	// ========================================
	// frame layout and sizes
	// ========================================

	localparam int ID_OFFSET  = 22; // copy id byte position in header
	localparam int NUM_COPIES = 3;
	localparam int BUF_DEPTH  = 64; // payload bytes per copy
	localparam int READ_PIPE  = 2;  // address to registered output

	localparam int ADDR_W = $clog2(BUF_DEPTH);
	localparam int LEN_W  = $clog2(BUF_DEPTH + 1);
	localparam int ID_W   = $clog2(NUM_COPIES + 1);
	localparam int OFS_W  = $clog2(ID_OFFSET + 2); // header offset, saturates

	// ========================================
	// shared types
	// ========================================

	typedef logic [7:0]            byte_t;
	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [LEN_W-1:0]      len_t;      // 0 to BUF_DEPTH
	typedef logic [ID_W-1:0]       copy_id_t;  // 0 means no valid copy
	typedef logic [NUM_COPIES-1:0] copy_mask_t; // bit 0 is copy 1
	typedef logic [OFS_W-1:0]      ofs_t;

	// collector states
	typedef enum logic [2:0] {
		IDLE,
		GOT1,
		GOT2,
		VOTE,
		PLAY
	} state_t;

endpackage

//--- source/frame_parser.sv
`timescale 1ns/1ps

module frame_parser (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rx_en,
	input  merge_pkg::byte_t      rx_data,
	input  logic                  capture_en,
	output merge_pkg::copy_mask_t wr_mask,
	output merge_pkg::addr_t      wr_addr,
	output merge_pkg::byte_t      wr_data,
	output logic                  frame_done,
	output merge_pkg::copy_id_t   done_id,
	output merge_pkg::len_t       done_len
);
	import merge_pkg::*;

	logic     rx_en_q;
	logic     rx_en_d;
	byte_t    rx_data_q;
	ofs_t     offset;     // offset of the byte now in rx_data_q
	copy_id_t cur_id;
	len_t     pay_len;    // payload bytes stored so far
	logic     at_payload;
	logic     id_ok;
	logic     wr_go;

	assign at_payload = (offset == ofs_t'(ID_OFFSET + 1)); // past the id byte
	assign id_ok      = (rx_data_q >= 8'd1) && (rx_data_q <= byte_t'(NUM_COPIES));

	// a payload byte goes to the buffer of its copy, until the buffer is full
	assign wr_go   = rx_en_q && at_payload && capture_en && (cur_id != '0) &&
	                 (pay_len < len_t'(BUF_DEPTH));
	assign wr_mask = wr_go ? (copy_mask_t'(1) << (cur_id - 2'd1)) : '0;
	assign wr_addr = addr_t'(pay_len);
	assign wr_data = rx_data_q;

	always_ff @(posedge clk) begin
		rx_data_q <= rx_data;
		done_id   <= (pay_len != '0) ? cur_id : '0; // empty frame reports no id
		done_len  <= pay_len;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rx_en_q    <= 1'b0;
			rx_en_d    <= 1'b0;
			offset     <= '0;
			cur_id     <= '0;
			pay_len    <= '0;
			frame_done <= 1'b0;
		end else begin
			rx_en_q    <= rx_en;
			rx_en_d    <= rx_en_q;
			frame_done <= rx_en_d && !rx_en_q; // falling edge of the frame

			if (!rx_en_q) begin
				offset <= '0;
			end else if (!at_payload) begin
				offset <= offset + 1'b1;
			end

			if (rx_en_q && (offset == '0)) begin
				cur_id  <= '0; // new frame
				pay_len <= '0;
			end else if (rx_en_q && (offset == ofs_t'(ID_OFFSET))) begin
				cur_id <= id_ok ? copy_id_t'(rx_data_q) : '0;
			end else if (wr_go) begin
				pay_len <= pay_len + 1'b1;
			end
		end
	end

endmodule

//--- source/copy_buffer.sv
`timescale 1ns/1ps

module copy_buffer (
	input  logic             clk,
	input  logic             wr_en,
	input  merge_pkg::addr_t wr_addr,
	input  merge_pkg::byte_t wr_data,
	input  merge_pkg::addr_t rd_addr,
	output merge_pkg::byte_t rd_data
);
	import merge_pkg::*;

	byte_t mem [BUF_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
		rd_data <= mem[rd_addr]; // one cycle read
	end

endmodule

//--- source/sweep_counter.sv
`timescale 1ns/1ps

module sweep_counter (
	input  logic             clk,
	input  logic             reset,
	input  logic             sweep_start,
	input  merge_pkg::len_t  sweep_len,
	output merge_pkg::addr_t rd_addr,
	output logic             sweep_done
);
	import merge_pkg::*;

	len_t                 cnt;
	len_t                 len_q;
	logic                 active;
	logic                 last_step;
	logic [READ_PIPE-1:0] done_pipe; // end pulse waits for the read data

	// a zero length still spends one address cycle
	assign last_step  = active && ((cnt + 1'b1) >= len_q);
	assign rd_addr    = addr_t'(cnt);
	assign sweep_done = done_pipe[READ_PIPE-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			cnt       <= '0;
			len_q     <= '0;
			done_pipe <= '0;
		end else begin
			done_pipe <= {done_pipe[READ_PIPE-2:0], last_step};
			if (sweep_start) begin
				active <= 1'b1;
				cnt    <= '0;
				len_q  <= sweep_len;
			end else if (last_step) begin
				active <= 1'b0;
			end else if (active) begin
				cnt <= cnt + 1'b1; // next address
			end
		end
	end

endmodule

//--- source/copy_voter.sv
`timescale 1ns/1ps

module copy_voter (
	input  logic                clk,
	input  logic                reset,
	input  logic                frame_done,
	input  merge_pkg::copy_id_t done_id,
	input  merge_pkg::len_t     done_len,
	input  logic                sweep_start,
	input  logic                play,
	input  merge_pkg::byte_t    rd_data1,
	input  merge_pkg::byte_t    rd_data2,
	input  merge_pkg::byte_t    rd_data3,
	output merge_pkg::len_t     sweep_len,
	output logic                all_equal,
	output logic                select_valid,
	output merge_pkg::byte_t    data_out,
	output logic                en_out
);
	import merge_pkg::*;

	len_t  copy_len [NUM_COPIES];
	len_t  beat_left; // addresses still to come in this sweep
	logic  beat_vld;  // read data of this cycle belongs to the sweep
	logic  mm12;
	logic  mm13;
	logic  mm23;
	logic  agree12;
	logic  agree13;
	logic  agree23;
	logic  sel1;
	len_t  min12;
	len_t  min_len;
	byte_t sel_byte;

	// ========================================
	// pair agreement and selection
	// ========================================

	assign agree12 = (copy_len[0] == copy_len[1]) && !mm12;
	assign agree13 = (copy_len[0] == copy_len[2]) && !mm13;
	assign agree23 = (copy_len[1] == copy_len[2]) && !mm23;

	assign all_equal    = agree12 && agree13 && agree23;
	assign sel1         = agree12 || agree13; // copy 1 preferred
	assign select_valid = sel1 || agree23;

	assign min12     = (copy_len[0] < copy_len[1]) ? copy_len[0] : copy_len[1];
	assign min_len   = (min12 < copy_len[2]) ? min12 : copy_len[2];
	assign sweep_len = play ? (sel1 ? copy_len[0] : copy_len[1]) : min_len;
	assign sel_byte  = sel1 ? rd_data1 : rd_data2;

	always_ff @(posedge clk) begin
		if (frame_done && (done_id != '0)) begin
			copy_len[done_id - 2'd1] <= done_len;
		end
		if (beat_vld && play) begin
			data_out <= sel_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			beat_left <= '0;
			beat_vld  <= 1'b0;
			mm12      <= 1'b0;
			mm13      <= 1'b0;
			mm23      <= 1'b0;
			en_out    <= 1'b0;
		end else begin
			beat_vld <= (beat_left != '0);
			en_out   <= beat_vld && play;
			if (sweep_start) begin
				beat_left <= sweep_len;
			end else if (beat_left != '0) begin
				beat_left <= beat_left - 1'b1;
			end

			if (sweep_start && !play) begin
				mm12 <= 1'b0; // fresh vote
				mm13 <= 1'b0;
				mm23 <= 1'b0;
			end else if (beat_vld && !play) begin
				mm12 <= mm12 || (rd_data1 != rd_data2);
				mm13 <= mm13 || (rd_data1 != rd_data3);
				mm23 <= mm23 || (rd_data2 != rd_data3);
			end
		end
	end

endmodule

//--- source/group_fsm.sv
`timescale 1ns/1ps

module group_fsm (
	input  logic                clk,
	input  logic                reset,
	input  logic                frame_done,
	input  merge_pkg::copy_id_t done_id,
	input  logic                sweep_done,
	input  logic                all_equal,
	input  logic                select_valid,
	output logic                capture_en,
	output logic                sweep_start,
	output logic                play,
	output logic                lost
);
	import merge_pkg::*;

	state_t state;
	state_t state_next;
	logic   lost_next;
	logic   start_next;

	assign play = (state == PLAY);

	// ========================================
	// next state
	// ========================================

	always_comb begin
		state_next = state;
		lost_next  = 1'b0;
		start_next = 1'b0;
		case (state)
			IDLE: begin
				if (frame_done) begin
					if (done_id == 2'd1) begin
						state_next = GOT1;
					end else begin
						lost_next = 1'b1; // group did not start with copy 1
					end
				end
			end
			GOT1: begin
				if (frame_done) begin
					lost_next = (done_id != 2'd2);
					if (done_id == 2'd2) begin
						state_next = GOT2;
					end else if (done_id != 2'd1) begin
						state_next = IDLE;
					end
				end
			end
			GOT2: begin
				if (frame_done) begin
					lost_next = (done_id != 2'd3);
					if (done_id == 2'd3) begin
						state_next = VOTE;
						start_next = 1'b1; // compare pass
					end else if (done_id == 2'd1) begin
						state_next = GOT1; // restart group
					end else begin
						state_next = IDLE;
					end
				end
			end
			VOTE: begin
				if (sweep_done) begin
					if (select_valid) begin
						state_next = PLAY;
						start_next = 1'b1; // playback pass
						lost_next  = !all_equal;
					end else begin
						state_next = IDLE;
						lost_next  = 1'b1; // no two copies agree
					end
				end
			end
			PLAY: begin
				if (sweep_done) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			lost        <= 1'b0;
			sweep_start <= 1'b0;
			capture_en  <= 1'b0;
		end else begin
			state       <= state_next;
			lost        <= lost_next;
			sweep_start <= start_next;
			capture_en  <= (state_next == IDLE) || (state_next == GOT1) ||
			               (state_next == GOT2);
		end
	end

endmodule

//--- source/frame_merger_top.sv
`timescale 1ns/1ps

module frame_merger_top (
	input  logic             clk,
	input  logic             reset,
	input  logic             rx_en,
	input  merge_pkg::byte_t rx_data,
	output merge_pkg::byte_t data_out,
	output logic             en_out,
	output logic             lost
);
	import merge_pkg::*;

	copy_mask_t wr_mask;
	addr_t      wr_addr;
	byte_t      wr_data;
	logic       frame_done;
	copy_id_t   done_id;
	len_t       done_len;
	logic       capture_en;
	logic       sweep_start;
	logic       play;
	addr_t      rd_addr;
	logic       sweep_done;
	len_t       sweep_len;
	logic       all_equal;
	logic       select_valid;
	byte_t      rd_data [NUM_COPIES];

	frame_parser i_parser (
		.clk        (clk),
		.reset      (reset),
		.rx_en      (rx_en),
		.rx_data    (rx_data),
		.capture_en (capture_en),
		.wr_mask    (wr_mask),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_done (frame_done),
		.done_id    (done_id),
		.done_len   (done_len)
	);

	// one store per copy, all read at the same address
	for (genvar i = 0; i < NUM_COPIES; i++) begin : g_buf
		copy_buffer i_buf (
			.clk     (clk),
			.wr_en   (wr_mask[i]),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.rd_addr (rd_addr),
			.rd_data (rd_data[i])
		);
	end

	sweep_counter i_counter (
		.clk         (clk),
		.reset       (reset),
		.sweep_start (sweep_start),
		.sweep_len   (sweep_len),
		.rd_addr     (rd_addr),
		.sweep_done  (sweep_done)
	);

	copy_voter i_voter (
		.clk          (clk),
		.reset        (reset),
		.frame_done   (frame_done),
		.done_id      (done_id),
		.done_len     (done_len),
		.sweep_start  (sweep_start),
		.play         (play),
		.rd_data1     (rd_data[0]),
		.rd_data2     (rd_data[1]),
		.rd_data3     (rd_data[2]),
		.sweep_len    (sweep_len),
		.all_equal    (all_equal),
		.select_valid (select_valid),
		.data_out     (data_out),
		.en_out       (en_out)
	);

	group_fsm i_fsm (
		.clk          (clk),
		.reset        (reset),
		.frame_done   (frame_done),
		.done_id      (done_id),
		.sweep_done   (sweep_done),
		.all_equal    (all_equal),
		.select_valid (select_valid),
		.capture_en   (capture_en),
		.sweep_start  (sweep_start),
		.play         (play),
		.lost         (lost)
	);

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- verif/frame_merger_asserts.sv
`timescale 1ns/1ps

module frame_merger_asserts (
	input logic                  clk,
	input logic                  reset,
	input logic                  lost,
	input logic                  en_out,
	input logic                  play,
	input merge_pkg::copy_mask_t wr_mask
);

	int fail_cnt = 0; // failed assertions

	a_lost_pulse: assert property (@(posedge clk) disable iff (reset) lost |=> !lost)
	else begin
		$error("lost high on two consecutive cycles");
		fail_cnt++;
	end

	a_mask_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_mask))
	else begin
		$error("write mask has more than one bit set");
		fail_cnt++;
	end

	a_en_in_play: assert property (@(posedge clk) disable iff (reset) en_out |-> play)
	else begin
		$error("en_out high outside playback");
		fail_cnt++;
	end

	a_reset_quiet: assert property (@(posedge clk) reset |=> (!en_out && !lost))
	else begin
		$error("output active right after reset");
		fail_cnt++;
	end

endmodule

bind frame_merger_top frame_merger_asserts i_asserts (
	.clk     (clk),
	.reset   (reset),
	.lost    (lost),
	.en_out  (en_out),
	.play    (play),
	.wr_mask (wr_mask)
);

//--- verif/frame_merger_tb.sv
`timescale 1ns/1ps

module frame_merger_tb;

	localparam int SEED        = 15205;
	localparam int HDR_LEN     = 22; // id byte sits right after the header
	localparam int MAX_PAYLOAD = 64;
	localparam int PAY_LEN     = 16;
	localparam int GAP         = 4;  // idle cycles between frames
	localparam int NUM_TESTS   = 7;
	localparam int WATCHDOG_CYCLES = 2 * NUM_TESTS * 3 * (HDR_LEN + MAX_PAYLOAD + 20);

	logic       clk;
	logic       reset;
	logic       rx_en;
	logic [7:0] rx_data;
	logic [7:0] data_out;
	logic       en_out;
	logic       lost;

	logic [7:0] pay [3][MAX_PAYLOAD]; // payload of each copy
	int         pay_len [3];
	logic [7:0] out_q [$];
	int         lost_cnt;
	int         fall_cnt;
	logic       en_prev;
	int         err_cnt;
	int         chk_cnt;

	tb_clock i_clock (
		.clk   (clk),
		.reset (reset)
	);

	frame_merger_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.rx_en    (rx_en),
		.rx_data  (rx_data),
		.data_out (data_out),
		.en_out   (en_out),
		.lost     (lost)
	);

	// ========================================
	// output monitor and watchdog
	// ========================================

	always @(posedge clk) begin
		if (reset) begin
			en_prev <= 1'b0;
		end else begin
			if (en_out) begin
				out_q.push_back(data_out);
			end
			if (lost) begin
				lost_cnt++;
			end
			if (en_prev && !en_out) begin
				fall_cnt++; // end of playback
			end
			en_prev <= en_out;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ========================================
	// helpers
	// ========================================

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic clear_monitor();
		out_q.delete();
		lost_cnt = 0;
		fall_cnt = 0;
	endtask

	task automatic make_payloads(input int len);
		logic [31:0] word;
		for (int i = 0; i < len; i++) begin
			word = $urandom;
			for (int c = 0; c < 3; c++) begin
				pay[c][i] = word[7:0]; // identical copies
			end
		end
		for (int c = 0; c < 3; c++) begin
			pay_len[c] = len;
		end
	endtask

	task automatic send_frame(input int c, input logic [7:0] id);
		logic [31:0] word;
		for (int i = 0; i < HDR_LEN; i++) begin
			word = 32'h50 + i;
			@(posedge clk);
			rx_en   <= 1'b1;
			rx_data <= word[7:0];
		end
		@(posedge clk);
		rx_data <= id;
		for (int i = 0; i < pay_len[c]; i++) begin
			@(posedge clk);
			rx_data <= pay[c][i];
		end
		@(posedge clk);
		rx_en   <= 1'b0;
		rx_data <= 8'h00;
		repeat (GAP) @(posedge clk);
	endtask

	// group ends on en_out falling, or on a lost pulse that no output follows
	task automatic wait_group_end();
		int quiet;
		quiet = 0;
		while ((fall_cnt == 0) && (quiet < 8)) begin
			@(negedge clk);
			if (en_out) begin
				quiet = 0;
			end else if (lost_cnt != 0) begin
				quiet++;
			end
		end
		repeat (10) @(posedge clk);
	endtask

	task automatic check_group(input int sel, input int exp_lost);
		int exp_len;
		exp_len = (sel < 0) ? 0 : pay_len[sel];
		check_value("data_out count", out_q.size(), exp_len);
		check_value("lost", lost_cnt, exp_lost);
		for (int i = 0; (i < exp_len) && (i < out_q.size()); i++) begin
			check_value($sformatf("data_out[%0d]", i), out_q[i], pay[sel][i]);
		end
	endtask

	task automatic run_group(input int sel, input int exp_lost);
		clear_monitor();
		send_frame(0, 8'd1);
		send_frame(1, 8'd2);
		send_frame(2, 8'd3);
		wait_group_end();
		check_group(sel, exp_lost);
	endtask

	// ========================================
	// directed tests
	// ========================================

	task automatic test_idle_after_reset();
		clear_monitor();
		repeat (20) @(posedge clk);
		check_group(-1, 0);
	endtask

	task automatic test_clean_group();
		make_payloads(PAY_LEN);
		run_group(0, 0);
	endtask

	task automatic test_copy3_corrupt();
		make_payloads(PAY_LEN);
		pay[2][5] ^= 8'hff;
		run_group(0, 1);
	endtask

	task automatic test_copy1_corrupt();
		make_payloads(PAY_LEN);
		pay[0][9] ^= 8'h01;
		run_group(1, 1); // copies 2 and 3 win
	endtask

	task automatic test_short_copy3();
		make_payloads(PAY_LEN);
		pay_len[2] = PAY_LEN - 4;
		run_group(0, 1);
	endtask

	task automatic test_no_majority();
		make_payloads(PAY_LEN);
		pay[0][2]  ^= 8'h10;
		pay[1][7]  ^= 8'h20;
		pay[2][11] ^= 8'h40;
		run_group(-1, 1);
	endtask

	task automatic test_bad_start();
		make_payloads(PAY_LEN);
		clear_monitor();
		send_frame(1, 8'd2); // copy 2 with no copy 1 before it
		wait_group_end();
		check_group(-1, 1);
		make_payloads(PAY_LEN);
		run_group(0, 0);
	endtask

	initial begin
		rx_en   = 1'b0;
		rx_data = 8'h00;
		err_cnt = 0;
		chk_cnt = 0;
		void'($urandom(SEED));
		clear_monitor();
		wait (reset == 1'b0);
		@(posedge clk);
		test_idle_after_reset();
		test_clean_group();
		test_copy3_corrupt();
		test_copy1_corrupt();
		test_short_copy3();
		test_no_majority();
		test_bad_start();
		err_cnt += i_dut.i_asserts.fail_cnt;
		$display("checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- flist.f
source/merge_pkg.sv
source/frame_parser.sv
source/copy_buffer.sv
source/sweep_counter.sv
source/copy_voter.sv
source/group_fsm.sv
source/frame_merger_top.sv
verif/tb_clock.sv
verif/frame_merger_asserts.sv
verif/frame_merger_tb.sv

//--- Bender.yml
package:
  name: frame_merger

sources:
  - source/merge_pkg.sv
  - source/frame_parser.sv
  - source/copy_buffer.sv
  - source/sweep_counter.sv
  - source/copy_voter.sv
  - source/group_fsm.sv
  - source/frame_merger_top.sv
  - target: simulation
    files:
      - verif/tb_clock.sv
      - verif/frame_merger_asserts.sv
      - verif/frame_merger_tb.sv
